//--- logic/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// widths
`define EX_NB_DATA      32
`define EX_NB_REG       5
`define EX_NB_OP        6

// alu class from decode
`define EX_CLS_LDST     2'b00
`define EX_CLS_BRANCH   2'b01
`define EX_CLS_RTYPE    2'b10
`define EX_CLS_ITYPE    2'b11

// r-type funct codes
`define EX_OP_ADD       6'b100000
`define EX_OP_ADDU      6'b100001
`define EX_OP_SUB       6'b100010
`define EX_OP_SUBU      6'b100011
`define EX_OP_AND       6'b100100
`define EX_OP_OR        6'b100101
`define EX_OP_XOR       6'b100110
`define EX_OP_NOR       6'b100111
`define EX_OP_SLT       6'b101010
`define EX_OP_SLTU      6'b101011
`define EX_OP_SLL       6'b000000
`define EX_OP_SRL       6'b000010
`define EX_OP_SRA       6'b000011
`define EX_OP_SLLV      6'b000100
`define EX_OP_SRLV      6'b000110
`define EX_OP_SRAV      6'b000111
`define EX_OP_JALR      6'b001001

// primary opcodes
`define EX_OP_ADDI      6'b001000
`define EX_OP_ADDIU     6'b001001
`define EX_OP_ANDI      6'b001100
`define EX_OP_ORI       6'b001101
`define EX_OP_XORI      6'b001110
`define EX_OP_SLTI      6'b001010
`define EX_OP_SLTIU     6'b001011
`define EX_OP_LUI       6'b001111
`define EX_OP_JAL       6'b000011
`define EX_OP_RTYPE     6'b000000

// no operation, alu yields zero
`define EX_OP_IDLE      6'b111111

`endif

//--- logic/ex_pkg.sv
`include "ex_macros.svh"

package ex_pkg;

    // basic vectors
    typedef logic [`EX_NB_DATA-1:0] data_t;
    typedef logic [`EX_NB_REG-1:0]  reg_addr_t;
    typedef logic [`EX_NB_OP-1:0]   alu_op_t;
    typedef logic [1:0]             alu_class_t;
    // 00 register, 10 mem/wb, 11 ex/mem, 01 zero
    typedef logic [1:0]             fwd_sel_t;
    // memory access width
    typedef logic [1:0]             width_t;

    // control bits from decode
    typedef struct packed {
        logic       reg_dst;
        logic       mem2reg;
        logic       mem_write;
        logic       reg_write;
        logic       imm_flag;
        alu_class_t alu_class;
        width_t     width;
        logic       sign_flag;
    } ex_ctrl_t;

    // decoded instruction fields and register values
    typedef struct packed {
        data_t      reg_a;
        data_t      reg_b;
        data_t      immediate;
        logic [4:0] shamt;
        alu_op_t    opcode;
        alu_op_t    func;
        reg_addr_t  rt;
        reg_addr_t  rd;
    } ex_operands_t;

    // forwarding selects and bypass values
    typedef struct packed {
        fwd_sel_t fw_a;
        fwd_sel_t fw_b;
        data_t    exmem_result;
        data_t    memwb_result;
    } ex_fwd_t;

    typedef struct packed {
        alu_op_t    op;
        data_t      a;
        data_t      b;
        logic [4:0] shamt;
    } ex_alu_in_t;

    // contents of the ex/mem register
    typedef struct packed {
        logic      mem2reg;
        logic      mem_write;
        logic      reg_write;
        logic      sign_flag;
        width_t    width;
        reg_addr_t write_reg;
        data_t     data4mem;
        data_t     result;
    } ex_mem_t;

endpackage

//--- logic/ex_operand_select.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_operand_select
    import ex_pkg::*;
(
    input  ex_operands_t i_ops,
    input  ex_fwd_t      i_fwd,
    input  logic         i_imm_flag,
    output data_t        o_a,
    output data_t        o_b,
    output data_t        o_data4mem
);

    logic  is_link;
    data_t fwd_a;
    data_t fwd_b;

    // one forwarding mux, used for both operands
    function automatic data_t fwd_mux(
        input fwd_sel_t sel,
        input data_t    reg_val,
        input data_t    exmem_val,
        input data_t    memwb_val
    );
        data_t val;
        case (sel)
            2'b00:   val = reg_val;
            2'b10:   val = memwb_val;
            2'b11:   val = exmem_val;
            default: val = '0;
        endcase
        return val;
    endfunction

    // jal and jalr carry the link values, never forwarded
    assign is_link = (i_ops.opcode == `EX_OP_JAL) ||
                     ((i_ops.opcode == `EX_OP_RTYPE) && (i_ops.func == `EX_OP_JALR));

    assign fwd_a = fwd_mux(i_fwd.fw_a, i_ops.reg_a, i_fwd.exmem_result, i_fwd.memwb_result);
    assign fwd_b = fwd_mux(i_fwd.fw_b, i_ops.reg_b, i_fwd.exmem_result, i_fwd.memwb_result);

    // store word uses the forwarded rt value
    assign o_data4mem = fwd_b;

    always_comb begin
        o_a = fwd_a;
        if (is_link) begin
            o_a = i_ops.reg_a;
        end
    end

    always_comb begin
        o_b = fwd_b;
        if (is_link) begin
            o_b = i_ops.reg_b;
        end
        // immediate ops and address calculation
        if (i_imm_flag) begin
            o_b = i_ops.immediate;
        end
    end

endmodule

//--- logic/ex_alu_decode.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu_decode
    import ex_pkg::*;
(
    input  alu_class_t i_alu_class,
    input  alu_op_t    i_opcode,
    input  alu_op_t    i_func,
    output alu_op_t    o_op
);

    logic is_link;

    // link instructions compute the return address with an add
    assign is_link = (i_opcode == `EX_OP_JAL) ||
                     ((i_opcode == `EX_OP_RTYPE) && (i_func == `EX_OP_JALR));

    always_comb begin
        if (is_link) begin
            o_op = `EX_OP_ADD;
        end else begin
            case (i_alu_class)
                // effective address base + offset
                `EX_CLS_LDST: begin
                    o_op = `EX_OP_ADD;
                end
                // compare is resolved in decode
                `EX_CLS_BRANCH: begin
                    o_op = `EX_OP_IDLE;
                end
                `EX_CLS_RTYPE: begin
                    o_op = i_func;
                end
                `EX_CLS_ITYPE: begin
                    o_op = i_opcode;
                end
                default: begin
                    o_op = `EX_OP_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/ex_alu.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu
    import ex_pkg::*;
(
    input  ex_alu_in_t i_alu,
    output data_t      o_result
);

    data_t      a;
    data_t      b;
    logic [4:0] var_shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign a = i_alu.a;
    assign b = i_alu.b;

    // variable shifts take the amount from rs
    assign var_shamt = a[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (i_alu.op)
            // jalr shares its code with addiu
            `EX_OP_ADD,
            `EX_OP_ADDU,
            `EX_OP_ADDI,
            `EX_OP_ADDIU: begin
                o_result = a + b;
            end
            `EX_OP_SUB,
            `EX_OP_SUBU: begin
                o_result = a - b;
            end
            `EX_OP_AND,
            `EX_OP_ANDI: begin
                o_result = a & b;
            end
            `EX_OP_OR,
            `EX_OP_ORI: begin
                o_result = a | b;
            end
            `EX_OP_XOR,
            `EX_OP_XORI: begin
                o_result = a ^ b;
            end
            `EX_OP_NOR: begin
                o_result = ~(a | b);
            end
            `EX_OP_SLT,
            `EX_OP_SLTI: begin
                o_result = {31'b0, lt_signed};
            end
            `EX_OP_SLTU,
            `EX_OP_SLTIU: begin
                o_result = {31'b0, lt_unsigned};
            end
            `EX_OP_LUI: begin
                o_result = {b[15:0], 16'b0};
            end
            // fixed shifts by shamt
            `EX_OP_SLL: begin
                o_result = b << i_alu.shamt;
            end
            `EX_OP_SRL: begin
                o_result = b >> i_alu.shamt;
            end
            `EX_OP_SRA: begin
                o_result = $signed(b) >>> i_alu.shamt;
            end
            `EX_OP_SLLV: begin
                o_result = b << var_shamt;
            end
            `EX_OP_SRLV: begin
                o_result = b >> var_shamt;
            end
            `EX_OP_SRAV: begin
                o_result = $signed(b) >>> var_shamt;
            end
            // idle and unknown codes
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- logic/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_halt,
    input  ex_ctrl_t  i_ctrl,
    input  reg_addr_t i_rt,
    input  reg_addr_t i_rd,
    input  data_t     i_result,
    input  data_t     i_data4mem,
    output ex_mem_t   o_exmem
);

    reg_addr_t write_reg;
    ex_mem_t   exmem_next;

    // r-type writes rd, immediate and loads write rt
    assign write_reg = i_ctrl.reg_dst ? i_rd : i_rt;

    always_comb begin
        exmem_next.mem2reg   = i_ctrl.mem2reg;
        exmem_next.mem_write = i_ctrl.mem_write;
        exmem_next.reg_write = i_ctrl.reg_write;
        exmem_next.sign_flag = i_ctrl.sign_flag;
        exmem_next.width     = i_ctrl.width;
        exmem_next.write_reg = write_reg;
        exmem_next.data4mem  = i_data4mem;
        exmem_next.result    = i_result;
    end

    // whole register cleared, no write or store leaves reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exmem <= '0;
        end else if (!i_halt) begin
            o_exmem <= exmem_next;
        end
    end

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic         clk,
    input  logic         i_arst_n,
    input  logic         i_halt,
    input  ex_ctrl_t     i_ctrl,
    input  ex_operands_t i_ops,
    input  ex_fwd_t      i_fwd,
    output ex_mem_t      o_exmem
);

    data_t      alu_a;
    data_t      alu_b;
    data_t      data4mem;
    alu_op_t    alu_op;
    ex_alu_in_t alu_in;
    data_t      alu_result;

    // operand muxes with forwarding
    ex_operand_select u_operand_select (
        .i_ops      (i_ops),
        .i_fwd      (i_fwd),
        .i_imm_flag (i_ctrl.imm_flag),
        .o_a        (alu_a),
        .o_b        (alu_b),
        .o_data4mem (data4mem)
    );

    ex_alu_decode u_alu_decode (
        .i_alu_class (i_ctrl.alu_class),
        .i_opcode    (i_ops.opcode),
        .i_func      (i_ops.func),
        .o_op        (alu_op)
    );

    assign alu_in = '{op: alu_op, a: alu_a, b: alu_b, shamt: i_ops.shamt};

    ex_alu u_alu (
        .i_alu    (alu_in),
        .o_result (alu_result)
    );

    // ex/mem pipeline register
    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_halt     (i_halt),
        .i_ctrl     (i_ctrl),
        .i_rt       (i_ops.rt),
        .i_rd       (i_ops.rd),
        .i_result   (alu_result),
        .i_data4mem (data4mem),
        .o_exmem    (o_exmem)
    );

endmodule

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int MAX_CYCLES = 1000;
    localparam alu_op_t OP_LW  = 6'b100011;
    localparam alu_op_t OP_SW  = 6'b101011;
    localparam alu_op_t OP_BEQ = 6'b000100;

    logic         clk;
    logic         i_arst_n;
    logic         i_halt;
    ex_ctrl_t     i_ctrl;
    ex_operands_t i_ops;
    ex_fwd_t      i_fwd;
    ex_mem_t      o_exmem;

    integer  seed = 26711;
    int      cycles = 0;
    int      errors = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    logic    pending = 1'b0;
    ex_mem_t pending_exp;

    ex_stage u_ex_stage (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_halt   (i_halt),
        .i_ctrl   (i_ctrl),
        .i_ops    (i_ops),
        .i_fwd    (i_fwd),
        .o_exmem  (o_exmem)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the tests take roughly 150 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not complete", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic data_t rand32();
        return $random(seed);
    endfunction

    function automatic data_t fwd_pick(input fwd_sel_t sel, input data_t reg_val, input ex_fwd_t f);
        data_t v;
        case (sel)
            2'b00:   v = reg_val;
            2'b10:   v = f.memwb_result;
            2'b11:   v = f.exmem_result;
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b,
                                        input logic [4:0] sh);
        data_t r;
        case (op)
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_ADDI, `EX_OP_ADDIU: r = a + b;
            `EX_OP_SUB, `EX_OP_SUBU:  r = a - b;
            `EX_OP_AND, `EX_OP_ANDI:  r = a & b;
            `EX_OP_OR, `EX_OP_ORI:    r = a | b;
            `EX_OP_XOR, `EX_OP_XORI:  r = a ^ b;
            `EX_OP_NOR:               r = ~(a | b);
            `EX_OP_SLT, `EX_OP_SLTI:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `EX_OP_SLTU, `EX_OP_SLTIU: r = (a < b) ? 32'd1 : 32'd0;
            `EX_OP_LUI:  r = {b[15:0], 16'h0000};
            `EX_OP_SLL:  r = b << sh;
            `EX_OP_SRL:  r = b >> sh;
            `EX_OP_SRA:  r = $signed(b) >>> sh;
            `EX_OP_SLLV: r = b << a[4:0];
            `EX_OP_SRLV: r = b >> a[4:0];
            `EX_OP_SRAV: r = $signed(b) >>> a[4:0];
            default:     r = '0;
        endcase
        return r;
    endfunction

    // expected register contents for one instruction
    function automatic ex_mem_t model(input ex_ctrl_t c, input ex_operands_t o, input ex_fwd_t f);
        ex_mem_t e;
        logic    link;
        data_t   fa;
        data_t   fb;
        data_t   a;
        data_t   b;
        alu_op_t op;
        link = (o.opcode == `EX_OP_JAL) ||
               ((o.opcode == `EX_OP_RTYPE) && (o.func == `EX_OP_JALR));
        fa = fwd_pick(f.fw_a, o.reg_a, f);
        fb = fwd_pick(f.fw_b, o.reg_b, f);
        a = link ? o.reg_a : fa;
        b = c.imm_flag ? o.immediate : (link ? o.reg_b : fb);
        if (link) begin
            op = `EX_OP_ADD;
        end else begin
            case (c.alu_class)
                `EX_CLS_LDST:   op = `EX_OP_ADD;
                `EX_CLS_BRANCH: op = `EX_OP_IDLE;
                `EX_CLS_RTYPE:  op = o.func;
                default:        op = o.opcode;
            endcase
        end
        e.result    = alu_model(op, a, b, o.shamt);
        e.data4mem  = fb;
        e.write_reg = c.reg_dst ? o.rd : o.rt;
        e.mem2reg   = c.mem2reg;
        e.mem_write = c.mem_write;
        e.reg_write = c.reg_write;
        e.sign_flag = c.sign_flag;
        e.width     = c.width;
        return e;
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%02h got 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_ctrl(input ex_mem_t exp, input ex_mem_t act);
        logic [5:0] e;
        logic [5:0] a;
        e = {exp.mem2reg, exp.mem_write, exp.reg_write, exp.sign_flag, exp.width};
        a = {act.mem2reg, act.mem_write, act.reg_write, act.sign_flag, act.width};
        if (a !== e) begin
            errors++;
            $display("[ERROR] o_exmem.{mem2reg,mem_write,reg_write,sign_flag,width} %s",
                     $sformatf("expected 0x%02h got 0x%02h", e, a));
        end
    endtask

    task automatic check_exmem(input ex_mem_t exp);
        check_ctrl(exp, o_exmem);
        check_reg("o_exmem.write_reg", exp.write_reg, o_exmem.write_reg);
        check_data("o_exmem.data4mem", exp.data4mem, o_exmem.data4mem);
        check_data("o_exmem.result", exp.result, o_exmem.result);
    endtask

    // drive one instruction, check the one before it
    task automatic apply(input ex_ctrl_t c, input ex_operands_t o, input ex_fwd_t f);
        @(posedge clk);
        i_ctrl <= c;
        i_ops  <= o;
        i_fwd  <= f;
        @(negedge clk);
        if (pending) begin
            check_exmem(pending_exp);
        end
        pending_exp = model(c, o, f);
        pending = 1'b1;
    endtask

    task automatic flush();
        @(posedge clk);
        @(negedge clk);
        if (pending) begin
            check_exmem(pending_exp);
        end
        pending = 1'b0;
    endtask

    function automatic ex_operands_t rand_ops(input alu_op_t opcode, input alu_op_t func);
        ex_operands_t o;
        data_t        r;
        r = rand32();
        o.reg_a     = rand32();
        o.reg_b     = rand32();
        o.immediate = {{16{r[31]}}, r[31:16]};
        o.shamt     = r[4:0];
        o.rt        = r[9:5];
        o.rd        = r[14:10];
        o.opcode    = opcode;
        o.func      = func;
        return o;
    endfunction

    function automatic ex_fwd_t rand_fwd(input logic use_codes);
        ex_fwd_t f;
        data_t   r;
        r = rand32();
        f.fw_a         = use_codes ? r[1:0] : 2'b00;
        f.fw_b         = use_codes ? r[3:2] : 2'b00;
        f.exmem_result = rand32();
        f.memwb_result = rand32();
        return f;
    endfunction

    function automatic ex_ctrl_t rand_ctrl(input alu_class_t cls, input logic imm, input logic dst);
        ex_ctrl_t c;
        data_t    r;
        r = rand32();
        c           = '0;
        c.alu_class = cls;
        c.imm_flag  = imm;
        c.reg_dst   = dst;
        c.width     = r[1:0];
        c.sign_flag = r[2];
        c.mem2reg   = r[3];
        c.mem_write = r[4];
        c.reg_write = r[5];
        return c;
    endfunction

    task automatic report(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - err_start);
        end
    endtask

    task automatic test_reset();
        ex_ctrl_t     c;
        ex_operands_t o;
        ex_fwd_t      f;
        int           e0;
        e0 = errors;
        c = rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1);
        o = rand_ops(`EX_OP_RTYPE, `EX_OP_ADD);
        f = rand_fwd(1'b1);
        // a live instruction waits on the inputs while reset holds the register
        @(posedge clk);
        i_ctrl <= c;
        i_ops  <= o;
        i_fwd  <= f;
        repeat (16) begin
            @(negedge clk);
            check_exmem('0);
        end
        @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        check_exmem('0);
        // first edge after release loads the waiting instruction
        pending_exp = model(c, o, f);
        pending = 1'b1;
        flush();
        report("reset", e0);
    endtask

    task automatic test_rtype();
        alu_op_t funcs[17] = '{`EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU, `EX_OP_AND,
                               `EX_OP_OR, `EX_OP_XOR, `EX_OP_NOR, `EX_OP_SLT, `EX_OP_SLTU,
                               `EX_OP_SLL, `EX_OP_SRL, `EX_OP_SRA, `EX_OP_SLLV, `EX_OP_SRLV,
                               `EX_OP_SRAV, `EX_OP_JALR};
        int e0;
        e0 = errors;
        for (int n = 0; n < 2; n++) begin
            foreach (funcs[i]) begin
                apply(rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1), rand_ops(`EX_OP_RTYPE, funcs[i]),
                      rand_fwd(1'b0));
            end
        end
        flush();
        report("rtype", e0);
    endtask

    task automatic test_itype();
        alu_op_t ops[8] = '{`EX_OP_ADDI, `EX_OP_ADDIU, `EX_OP_ANDI, `EX_OP_ORI,
                            `EX_OP_XORI, `EX_OP_SLTI, `EX_OP_SLTIU, `EX_OP_LUI};
        int e0;
        e0 = errors;
        for (int n = 0; n < 3; n++) begin
            foreach (ops[i]) begin
                apply(rand_ctrl(`EX_CLS_ITYPE, 1'b1, 1'b0), rand_ops(ops[i], 6'b010101),
                      rand_fwd(1'b0));
            end
        end
        flush();
        report("itype", e0);
    endtask

    task automatic test_forward();
        fwd_sel_t sels[4] = '{2'b00, 2'b01, 2'b10, 2'b11};
        ex_fwd_t  f;
        ex_ctrl_t c;
        int       e0;
        e0 = errors;
        foreach (sels[i]) begin
            foreach (sels[j]) begin
                f = rand_fwd(1'b0);
                f.fw_a = sels[i];
                f.fw_b = sels[j];
                apply(rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1), rand_ops(`EX_OP_RTYPE, `EX_OP_ADD), f);
            end
        end
        // loads and stores take the address from the forwarded base
        for (int n = 0; n < 8; n++) begin
            c = rand_ctrl(`EX_CLS_LDST, 1'b1, 1'b0);
            c.mem2reg   = (n % 2 == 0);
            c.reg_write = (n % 2 == 0);
            c.mem_write = (n % 2 == 1);
            apply(c, rand_ops((n % 2 == 0) ? OP_LW : OP_SW, 6'b000000), rand_fwd(1'b1));
        end
        flush();
        report("forward", e0);
    endtask

    task automatic test_link_branch();
        int e0;
        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            apply(rand_ctrl(`EX_CLS_ITYPE, 1'b0, 1'b0), rand_ops(`EX_OP_JAL, 6'b000000),
                  rand_fwd(1'b1));
            apply(rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1), rand_ops(`EX_OP_RTYPE, `EX_OP_JALR),
                  rand_fwd(1'b1));
            apply(rand_ctrl(`EX_CLS_BRANCH, 1'b0, 1'b0), rand_ops(OP_BEQ, 6'b000000),
                  rand_fwd(1'b1));
        end
        flush();
        report("link_branch", e0);
    endtask

    task automatic test_halt();
        ex_ctrl_t     c;
        ex_operands_t o;
        ex_fwd_t      f;
        ex_mem_t      held;
        int           e0;
        e0 = errors;
        apply(rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1), rand_ops(`EX_OP_RTYPE, `EX_OP_SUB),
              rand_fwd(1'b0));
        held = pending_exp;
        flush();
        @(posedge clk);
        i_halt <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            i_ctrl <= rand_ctrl(`EX_CLS_RTYPE, 1'b0, 1'b1);
            i_ops  <= rand_ops(`EX_OP_RTYPE, `EX_OP_XOR);
            i_fwd  <= rand_fwd(1'b1);
            @(negedge clk);
            check_exmem(held);
        end
        // release together with the next instruction
        c = rand_ctrl(`EX_CLS_ITYPE, 1'b1, 1'b0);
        o = rand_ops(`EX_OP_ORI, 6'b000000);
        f = rand_fwd(1'b0);
        @(posedge clk);
        i_halt <= 1'b0;
        i_ctrl <= c;
        i_ops  <= o;
        i_fwd  <= f;
        @(negedge clk);
        check_exmem(held);
        @(posedge clk);
        @(negedge clk);
        check_exmem(model(c, o, f));
        report("halt", e0);
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_halt   = 1'b0;
        i_ctrl   = '0;
        i_ops    = '0;
        i_fwd    = '0;
        test_reset();
        test_rtype();
        test_itype();
        test_forward();
        test_link_branch();
        test_halt();
        $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- ex_stage.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_operand_select.sv
logic/ex_alu_decode.sv
logic/ex_alu.sv
logic/ex_mem_reg.sv
logic/ex_stage.sv
test/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_ex_stage -f ex_stage.f; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ex_stage 2>&1); then
    echo "$sim_out"
    echo "simulation binary returned an error status"
    exit 1
fi

echo "$sim_out"

# result decided by the testbench's own verdict line
if grep -qx "Simulation passed" <<< "$sim_out"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
